/* list.f */
+incdir+src
src/stbuf_pkg.sv
src/lsu_req_pkg.sv
src/stbuf_alloc.sv
src/stbuf_entries.sv
src/stbuf_fwd.sv
src/store_buffer.sv
tb/store_buffer_asserts.sv
tb/store_buffer_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= store_buffer_tb
FLIST     ?= list.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --assert --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the store buffer testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD VFLAGS"

$(BUILD)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

test: $(BUILD)/V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(BUILD)

/* tb/store_buffer_tb.sv */
//--------------------------------------------------------------------------
// testbench for the store buffer
// random stores, commits, drain acks and loads against a queue model;
// run through the Makefile test target
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module store_buffer_tb;

   typedef struct {
      logic [13:0] addr;
      logic [3:0]  be;
      logic [31:0] data;
      bit          cmt;
      bit          flsh;
      int          tag;
   } ent_t;

   logic clk, rst, st_valid, st_commit, drain_ack, ld_valid;
   logic [15:0] st_addr;
   logic [1:0]  st_size;
   logic [31:0] st_data;
   logic [13:0] ld_addr;
   logic full, empty, drain_valid, fwd_valid;
   logic [13:0] drain_addr;
   logic [3:0]  drain_byteen, fwd_byteen;
   logic [31:0] drain_data, fwd_data;

   ent_t        q[$];                      // model entries in age order
   bit          s_vld[2];                  // model resolve pipe
   bit          s_cmt[2];
   int          s_tag[2];
   bit          cur_cmt;
   int          next_tag, errors, timeouts, drained, seed_val;
   bit          exp_fwd_vld;
   logic [3:0]  exp_fwd_be;
   logic [31:0] exp_fwd_data;
   string       phase;                     // name of the running test

   store_buffer i_dut (.*);

   always #5 clk = ~clk;

   task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         errors++;
         $display("Error %s %s: expected %h, actual %h", phase, name, exp, act);
      end
   endtask

   task automatic check_outputs();
      bit dv;
      dv = q.size() > 0 && q[0].cmt;
      check("empty", 64'(q.size() == 0), 64'(empty));
      check("full", 64'(q.size() > 2), 64'(full));
      check("drain_valid", 64'(dv), 64'(drain_valid));
      if (dv) begin
         check("drain_addr", 64'(q[0].addr), 64'(drain_addr));
         check("drain_byteen", 64'(q[0].be), 64'(drain_byteen));
         check("drain_data", 64'(q[0].data), 64'(drain_data));
      end
      check("fwd_valid", 64'(exp_fwd_vld), 64'(fwd_valid));
      if (exp_fwd_vld) begin
         check("fwd_byteen", 64'(exp_fwd_be), 64'(fwd_byteen));
         check("fwd_data", 64'(exp_fwd_data), 64'(fwd_data));
      end
   endtask

   // ------------------------------------------------------------------------
   // reference model stepped at each rising edge
   // ------------------------------------------------------------------------
   task automatic update_model();
      logic [7:0]  be8;
      logic [63:0] d64;
      int          off;
      ent_t        e;
      exp_fwd_vld = ld_valid;
      if (ld_valid) begin                  // contents before the edge
         exp_fwd_be   = '0;
         exp_fwd_data = '0;
         foreach (q[i]) begin
            if (!q[i].flsh && q[i].addr == ld_addr) begin
               for (int j = 0; j < 4; j++) begin
                  if (q[i].be[j]) begin
                     exp_fwd_be[j]        = 1'b1;
                     exp_fwd_data[8*j +: 8] = q[i].data[8*j +: 8];
                  end
               end
            end
         end
      end
      if (q.size() > 0 && (q[0].flsh || (q[0].cmt && drain_ack))) begin
         if (q[0].cmt) begin
            drained++;
         end
         void'(q.pop_front());
      end
      if (s_vld[1]) begin
         foreach (q[i]) begin
            if (q[i].tag == s_tag[1]) begin
               q[i].cmt  = st_commit;
               q[i].flsh = !st_commit;
            end
         end
      end
      if (st_valid) begin
         off = int'(st_addr[1:0]);
         be8 = ((8'd1 << (1 << st_size)) - 8'd1) << off;
         d64 = 64'(st_data) << (off * 8);
         e.cmt  = 0;
         e.flsh = 0;
         e.tag  = next_tag;
         e.addr = st_addr[15:2];
         e.be   = be8[3:0];
         e.data = d64[31:0];
         q.push_back(e);
         if (off + (1 << st_size) > 4) begin    // crosses into the next word
            e.addr = st_addr[15:2] + 14'd1;
            e.be   = be8[7:4];
            e.data = d64[63:32];
            q.push_back(e);
         end
      end
      s_vld[1] = s_vld[0];
      s_cmt[1] = s_cmt[0];
      s_tag[1] = s_tag[0];
      s_vld[0] = st_valid;
      s_cmt[0] = cur_cmt;
      s_tag[0] = next_tag;
      next_tag++;
   endtask

   // one clock of stimulus with outputs checked before the edge
   task automatic drive_cycle(input bit want_st, input int p_cmt, input bit ack, input bit ldv);
      st_valid  = want_st && q.size() <= 2;
      st_addr   = 16'h0100 + 16'($urandom % 12);
      st_size   = 2'($urandom % 3);
      st_data   = $urandom;
      cur_cmt   = ($urandom % 100) < p_cmt;
      st_commit = s_vld[1] ? s_cmt[1] : 1'($urandom % 2);
      drain_ack = ack;
      ld_valid  = ldv;
      ld_addr   = 14'h0040 + 14'($urandom % 4);
      @(negedge clk);
      check_outputs();
      @(posedge clk);
      update_model();
      #1;
   endtask

   task automatic run_random(input int n, input int p_st, input int p_cmt, input int p_ack,
                             input int p_ld);
      repeat (n) begin
         drive_cycle(($urandom % 100) < p_st, p_cmt, ($urandom % 100) < p_ack,
                     ($urandom % 100) < p_ld);
      end
   endtask

   task automatic drain_all();
      int n;
      n = 0;
      while (!(empty && q.size() == 0 && !s_vld[0] && !s_vld[1]) && n < 100) begin
         drive_cycle(0, 100, 1, 0);
         n++;
      end
      if (n >= 100) begin
         timeouts++;
         $display("timeout: buffer did not become empty");
      end
   endtask

   initial begin
      clk          = 0;
      rst          = 1;
      st_valid     = 0;
      st_addr      = '0;
      st_size      = '0;
      st_data      = '0;
      st_commit    = 0;
      drain_ack    = 0;
      ld_valid     = 0;
      ld_addr      = '0;
      errors       = 0;
      timeouts     = 0;
      drained      = 0;
      next_tag     = 0;
      exp_fwd_vld  = 0;
      exp_fwd_be   = '0;
      exp_fwd_data = '0;
      s_vld[0]     = 0;
      s_vld[1]     = 0;
      phase        = "reset";
      seed_val     = $urandom(32'h1931cabf);
      repeat (8) @(posedge clk);
      #1 rst = 0;
      check_outputs();                     // idle state out of reset

      phase = "commit";
      run_random(300, 50, 100, 80, 20);    // committed stores of all sizes
      phase = "flush";
      run_random(300, 60, 50, 70, 30);     // commits and flushes mixed
      drain_all();

      // back-pressure until full and then release the drain
      phase = "backpressure";
      begin : hold_phase
         int n;
         n = 0;
         while (!full && n < 50) begin
            drive_cycle(1, 100, 0, 0);
            n++;
         end
         if (n >= 50) begin
            timeouts++;
            $display("timeout: full never rose with drain_ack low");
         end
         repeat (10) drive_cycle(1, 100, 0, 1);
      end
      drain_all();

      // overlapping stores and a load right after them
      phase = "forward";
      repeat (30) begin
         repeat (4) drive_cycle(1, 70, 0, 0);
         drive_cycle(0, 70, 0, 1);
         drive_cycle(0, 70, 1, 1);
         drain_all();
      end

      if (drained == 0) begin
         errors++;
         $display("no committed store ever reached the drain port");
      end
      $display("errors: %0d mismatches, %0d timeouts, %0d entries drained",
               errors, timeouts, drained);
      if (errors == 0 && timeouts == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* tb/store_buffer_asserts.sv */
//--------------------------------------------------------------------------
// concurrent checks on the entry flags, write targets and drain port
// bound into every stbuf_entries instance
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module store_buffer_asserts (
   input logic                   clk,
   input logic                   rst,
   input stbuf_pkg::entry_mask_t vld,
   input stbuf_pkg::entry_mask_t cmt,
   input stbuf_pkg::entry_mask_t flsh,
   input stbuf_pkg::entry_mask_t wr_mask,
   input logic                   drain_valid,
   input logic                   drain_ack,
   input stbuf_pkg::word_addr_t  drain_addr,
   input stbuf_pkg::byteen_t     drain_byteen,
   input stbuf_pkg::data_t       drain_data
);

   // an entry is resolved one way only
   a_cmt_flsh: assert property (@(posedge clk) disable iff (rst) (cmt & flsh) == '0)
      else $error("entry is both committed and flushed");

   a_flag_vld: assert property (@(posedge clk) disable iff (rst) ((cmt | flsh) & ~vld) == '0)
      else $error("commit or flush flag set on an invalid entry");

   // full keeps new writes off entries still in use
   a_wr_free: assert property (@(posedge clk) disable iff (rst) (wr_mask & vld) == '0)
      else $error("store written over an occupied entry");

   // head entry and its contents hold under back-pressure
   a_drain_hold: assert property (@(posedge clk) disable iff (rst)
                                  drain_valid && !drain_ack |=>
                                  drain_valid && $stable(drain_addr) &&
                                  $stable(drain_byteen) && $stable(drain_data))
      else $error("drain outputs changed while waiting for drain_ack");

endmodule

bind stbuf_entries store_buffer_asserts i_asserts (
   .clk, .rst, .vld, .cmt, .flsh, .wr_mask, .drain_valid, .drain_ack,
   .drain_addr, .drain_byteen, .drain_data
);

/* src/store_buffer.sv */
//--------------------------------------------------------------------------
// store buffer top level
// stores in, in-order drain with valid/ack, and one-cycle load
// forwarding; allocation, storage and forwarding live in submodules
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "stbuf_defs.svh"

module store_buffer (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      st_valid,
   input  lsu_req_pkg::byte_addr_t   st_addr,
   input  lsu_req_pkg::access_size_t st_size,
   input  stbuf_pkg::data_t          st_data,
   input  logic                      st_commit,    // sampled two cycles after the write
   output logic                      full,
   output logic                      empty,
   output logic                      drain_valid,
   output stbuf_pkg::word_addr_t     drain_addr,
   output stbuf_pkg::byteen_t        drain_byteen,
   output stbuf_pkg::data_t          drain_data,
   input  logic                      drain_ack,
   input  logic                      ld_valid,
   input  stbuf_pkg::word_addr_t     ld_addr,
   output logic                      fwd_valid,
   output stbuf_pkg::byteen_t        fwd_byteen,
   output stbuf_pkg::data_t          fwd_data
);

   // allocation to storage
   stbuf_pkg::entry_mask_t wr_mask;
   stbuf_pkg::word_addr_t  wr_addr_lo;
   stbuf_pkg::word_addr_t  wr_addr_hi;
   stbuf_pkg::byteen_t     wr_byteen_lo;
   stbuf_pkg::byteen_t     wr_byteen_hi;
   stbuf_pkg::data_t       wr_data_lo;
   stbuf_pkg::data_t       wr_data_hi;
   stbuf_pkg::entry_mask_t resolve_mask;
   logic                   resolve_commit;

   // storage to forwarding
   stbuf_pkg::entry_idx_t  rd_ptr;
   stbuf_pkg::entry_mask_t ent_live;
   stbuf_pkg::word_addr_t  ent_addr   [`STBUF_DEPTH];
   stbuf_pkg::byteen_t     ent_byteen [`STBUF_DEPTH];
   stbuf_pkg::data_t       ent_data   [`STBUF_DEPTH];

   stbuf_alloc i_alloc (
      .clk, .rst, .st_valid, .st_addr, .st_size, .st_data, .st_commit, .full,
      .wr_mask, .wr_addr_lo, .wr_addr_hi, .wr_byteen_lo, .wr_byteen_hi,
      .wr_data_lo, .wr_data_hi, .resolve_mask, .resolve_commit
   );

   stbuf_entries i_entries (
      .clk, .rst, .wr_mask, .wr_addr_lo, .wr_addr_hi, .wr_byteen_lo, .wr_byteen_hi,
      .wr_data_lo, .wr_data_hi, .resolve_mask, .resolve_commit, .drain_ack,
      .drain_valid, .drain_addr, .drain_byteen, .drain_data, .full, .empty,
      .rd_ptr, .ent_live, .ent_addr, .ent_byteen, .ent_data
   );

   stbuf_fwd i_fwd (
      .clk, .rst, .ld_valid, .ld_addr, .rd_ptr, .ent_live, .ent_addr, .ent_byteen,
      .ent_data, .fwd_valid, .fwd_byteen, .fwd_data
   );

endmodule

/* src/stbuf_fwd.sv */
//--------------------------------------------------------------------------
// load forwarding from the store buffer
// per byte, the youngest live entry at the load word wins; the merged
// lanes and data come out one cycle after the lookup
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "stbuf_defs.svh"

module stbuf_fwd (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   ld_valid,
   input  stbuf_pkg::word_addr_t  ld_addr,
   input  stbuf_pkg::entry_idx_t  rd_ptr,
   input  stbuf_pkg::entry_mask_t ent_live,
   input  stbuf_pkg::word_addr_t  ent_addr   [`STBUF_DEPTH],
   input  stbuf_pkg::byteen_t     ent_byteen [`STBUF_DEPTH],
   input  stbuf_pkg::data_t       ent_data   [`STBUF_DEPTH],
   output logic                   fwd_valid,
   output stbuf_pkg::byteen_t     fwd_byteen,
   output stbuf_pkg::data_t       fwd_data
);

   localparam int DEPTH = `STBUF_DEPTH;
   localparam int BYTES = `STBUF_BYTES;

   stbuf_pkg::entry_mask_t hit;
   stbuf_pkg::byteen_t     merge_byteen;
   stbuf_pkg::data_t       merge_data;

   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         hit[i] = ent_live[i] & (ent_addr[i] == ld_addr);
      end
   end

   // oldest first, so a younger hit overwrites the byte
   always_comb begin : merge
      stbuf_pkg::entry_idx_t idx;
      merge_byteen = '0;
      merge_data   = '0;                 // uncovered lanes read 0
      for (int k = 0; k < DEPTH; k++) begin
         idx = rd_ptr + stbuf_pkg::entry_idx_t'(k);
         for (int j = 0; j < BYTES; j++) begin
            if (hit[idx] & ent_byteen[idx][j]) begin
               merge_byteen[j]      = 1'b1;
               merge_data[8*j +: 8] = ent_data[idx][8*j +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         fwd_valid <= 1'b0;
      end else begin
         fwd_valid <= ld_valid;
      end
   end

   // result only loads on a lookup
   always_ff @(posedge clk) begin
      if (ld_valid) begin
         fwd_byteen <= merge_byteen;
         fwd_data   <= merge_data;
      end
   end

endmodule

/* src/stbuf_entries.sv */
//--------------------------------------------------------------------------
// entry storage of the store buffer
// holds address, lanes and data per entry with valid, commit and flush
// flags; drains committed entries in order and retires flushed ones
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "stbuf_defs.svh"

module stbuf_entries (
   input  logic                   clk,
   input  logic                   rst,
   input  stbuf_pkg::entry_mask_t wr_mask,
   input  stbuf_pkg::word_addr_t  wr_addr_lo,
   input  stbuf_pkg::word_addr_t  wr_addr_hi,
   input  stbuf_pkg::byteen_t     wr_byteen_lo,
   input  stbuf_pkg::byteen_t     wr_byteen_hi,
   input  stbuf_pkg::data_t       wr_data_lo,
   input  stbuf_pkg::data_t       wr_data_hi,
   input  stbuf_pkg::entry_mask_t resolve_mask,
   input  logic                   resolve_commit,
   input  logic                   drain_ack,
   output logic                   drain_valid,
   output stbuf_pkg::word_addr_t  drain_addr,
   output stbuf_pkg::byteen_t     drain_byteen,
   output stbuf_pkg::data_t       drain_data,
   output logic                   full,
   output logic                   empty,
   output stbuf_pkg::entry_idx_t  rd_ptr,
   output stbuf_pkg::entry_mask_t ent_live,
   output stbuf_pkg::word_addr_t  ent_addr   [`STBUF_DEPTH],
   output stbuf_pkg::byteen_t     ent_byteen [`STBUF_DEPTH],
   output stbuf_pkg::data_t       ent_data   [`STBUF_DEPTH]
);

   localparam int DEPTH = `STBUF_DEPTH;
   localparam int CNT_W = $clog2(DEPTH) + 1;

   stbuf_pkg::entry_mask_t vld;       // entry holds a store
   stbuf_pkg::entry_mask_t cmt;       // resolved, may drain
   stbuf_pkg::entry_mask_t flsh;      // resolved, to be dropped
   stbuf_pkg::entry_mask_t sel_hi;
   stbuf_pkg::entry_mask_t retire;
   stbuf_pkg::entry_mask_t cmt_set;
   stbuf_pkg::entry_mask_t flsh_set;
   logic                   head_flushed;
   logic                   rd_adv;
   logic [CNT_W-1:0]       num_vld;

   // --------------------------------------------------------------------------
   // write side
   // --------------------------------------------------------------------------
   // the hi word of a split store is the entry whose predecessor is also
   // being written
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         sel_hi[i] = wr_mask[i] & wr_mask[(i + DEPTH - 1) % DEPTH];
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (wr_mask[i]) begin
            ent_addr[i]   <= sel_hi[i] ? wr_addr_hi   : wr_addr_lo;
            ent_byteen[i] <= sel_hi[i] ? wr_byteen_hi : wr_byteen_lo;
            ent_data[i]   <= sel_hi[i] ? wr_data_hi   : wr_data_lo;
         end
      end
   end

   // --------------------------------------------------------------------------
   // flags
   // --------------------------------------------------------------------------
   assign cmt_set  = resolve_mask & {DEPTH{resolve_commit}};
   assign flsh_set = resolve_mask & {DEPTH{~resolve_commit}};
   assign retire   = rd_adv ? (stbuf_pkg::entry_mask_t'(1) << rd_ptr) : '0;

   always_ff @(posedge clk) begin
      if (rst) begin
         vld  <= '0;
         cmt  <= '0;
         flsh <= '0;
      end else begin
         vld  <= (vld | wr_mask) & ~retire;
         cmt  <= (cmt | cmt_set) & ~retire;
         flsh <= (flsh | flsh_set) & ~retire;
      end
   end

   assign ent_live = vld & ~flsh;   // unresolved entries count as live

   // --------------------------------------------------------------------------
   // drain and read pointer
   // --------------------------------------------------------------------------
   assign drain_valid  = vld[rd_ptr] & cmt[rd_ptr];
   assign head_flushed = vld[rd_ptr] & flsh[rd_ptr];    // dropped without output
   assign rd_adv       = (drain_valid & drain_ack) | head_flushed;

   assign drain_addr   = ent_addr[rd_ptr];
   assign drain_byteen = ent_byteen[rd_ptr];
   assign drain_data   = ent_data[rd_ptr];

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_ptr <= '0;
      end else if (rd_adv) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // occupancy
   always_comb begin
      num_vld = '0;
      for (int i = 0; i < DEPTH; i++) begin
         num_vld = num_vld + CNT_W'(vld[i]);
      end
   end

   // full leaves room for a split store
   assign full  = num_vld > CNT_W'(DEPTH - 2);
   assign empty = num_vld == '0;

endmodule

/* src/stbuf_alloc.sv */
//--------------------------------------------------------------------------
// store allocation for the store buffer
// turns a store request into one or two entry writes, owns the write
// pointer and tracks each store until its commit decision arrives
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "stbuf_defs.svh"

module stbuf_alloc (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      st_valid,
   input  lsu_req_pkg::byte_addr_t   st_addr,
   input  lsu_req_pkg::access_size_t st_size,
   input  stbuf_pkg::data_t          st_data,
   input  logic                      st_commit,
   input  logic                      full,
   output stbuf_pkg::entry_mask_t    wr_mask,
   output stbuf_pkg::word_addr_t     wr_addr_lo,
   output stbuf_pkg::word_addr_t     wr_addr_hi,
   output stbuf_pkg::byteen_t        wr_byteen_lo,
   output stbuf_pkg::byteen_t        wr_byteen_hi,
   output stbuf_pkg::data_t          wr_data_lo,
   output stbuf_pkg::data_t          wr_data_hi,
   output stbuf_pkg::entry_mask_t    resolve_mask,
   output logic                      resolve_commit
);

   localparam int LAT = `STBUF_RESOLVE_LAT;

   logic [2*`STBUF_BYTES-1:0]  lanes;        // access lanes before the shift
   logic [2*`STBUF_BYTES-1:0]  lanes_ext;    // 8-byte window
   logic [2*`STBUF_DATA_W-1:0] data_ext;
   logic                       split;
   logic                       wr_en;
   stbuf_pkg::entry_idx_t      wr_ptr;

   logic                       pipe_vld   [LAT];
   stbuf_pkg::entry_idx_t      pipe_ptr   [LAT];
   logic                       pipe_split [LAT];

   // entry at ptr, plus the one after it for a split store
   function automatic stbuf_pkg::entry_mask_t ptr_mask(input stbuf_pkg::entry_idx_t ptr,
                                                       input logic two);
      stbuf_pkg::entry_idx_t  nxt;
      stbuf_pkg::entry_mask_t m;
      nxt = ptr + 1'b1;
      m   = stbuf_pkg::entry_mask_t'(1) << ptr;
      if (two) begin
         m[nxt] = 1'b1;
      end
      return m;
   endfunction

   // --------------------------------------------------------------------------
   // lanes, data shift and split detect
   // --------------------------------------------------------------------------
   always_comb begin
      case (st_size)
         lsu_req_pkg::SZ_BYTE: lanes = 8'b0000_0001;
         lsu_req_pkg::SZ_HALF: lanes = 8'b0000_0011;
         lsu_req_pkg::SZ_WORD: lanes = 8'b0000_1111;
         default:              lanes = '0;
      endcase
   end

   assign lanes_ext = lanes << st_addr[1:0];
   assign data_ext  = {{`STBUF_DATA_W{1'b0}}, st_data} << {st_addr[1:0], 3'b000};
   assign split     = |lanes_ext[2*`STBUF_BYTES-1:`STBUF_BYTES];   // spilled past the word

   assign wr_byteen_lo = lanes_ext[`STBUF_BYTES-1:0];
   assign wr_byteen_hi = lanes_ext[2*`STBUF_BYTES-1:`STBUF_BYTES];
   assign wr_data_lo   = data_ext[`STBUF_DATA_W-1:0];
   assign wr_data_hi   = data_ext[2*`STBUF_DATA_W-1:`STBUF_DATA_W];
   assign wr_addr_lo   = st_addr[`STBUF_ADDR_W-1:2];
   assign wr_addr_hi   = wr_addr_lo + 1'b1;

   // --------------------------------------------------------------------------
   // write pointer
   // --------------------------------------------------------------------------
   assign wr_en   = st_valid & ~full;
   assign wr_mask = wr_en ? ptr_mask(wr_ptr, split) : '0;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
      end else if (wr_en) begin
         wr_ptr <= wr_ptr + stbuf_pkg::entry_idx_t'(split) + 1'b1;
      end
   end

   // --------------------------------------------------------------------------
   // resolve pipe, last stage lines up with st_commit
   // --------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int s = 0; s < LAT; s++) begin
            pipe_vld[s] <= 1'b0;
         end
      end else begin
         pipe_vld[0] <= wr_en;
         for (int s = 1; s < LAT; s++) begin
            pipe_vld[s] <= pipe_vld[s-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      pipe_ptr[0]   <= wr_ptr;
      pipe_split[0] <= split;
      for (int s = 1; s < LAT; s++) begin
         pipe_ptr[s]   <= pipe_ptr[s-1];
         pipe_split[s] <= pipe_split[s-1];
      end
   end

   assign resolve_mask   = pipe_vld[LAT-1] ? ptr_mask(pipe_ptr[LAT-1], pipe_split[LAT-1]) : '0;
   assign resolve_commit = pipe_vld[LAT-1] & st_commit;

endmodule

/* src/lsu_req_pkg.sv */
//--------------------------------------------------------------------------
// request side types for stores entering the buffer
// byte address and access size encoding as seen at the LSU port
//--------------------------------------------------------------------------

package lsu_req_pkg;

`include "stbuf_defs.svh"

   typedef logic [`STBUF_ADDR_W-1:0] byte_addr_t;

   // access size of a store
   typedef logic [1:0] access_size_t;

   localparam access_size_t SZ_BYTE = 2'd0;
   localparam access_size_t SZ_HALF = 2'd1;
   localparam access_size_t SZ_WORD = 2'd2;   // 3 is unused

endpackage

/* src/stbuf_pkg.sv */
//--------------------------------------------------------------------------
// storage side types of the store buffer
// entry pointers, word addresses, lanes and data as held per entry
//--------------------------------------------------------------------------

package stbuf_pkg;

`include "stbuf_defs.svh"

   // pointer into the entry array
   typedef logic [$clog2(`STBUF_DEPTH)-1:0] entry_idx_t;

   // word address, byte offset dropped
   typedef logic [`STBUF_ADDR_W-3:0] word_addr_t;

   typedef logic [`STBUF_BYTES-1:0]  byteen_t;      // one bit per lane
   typedef logic [`STBUF_DATA_W-1:0] data_t;        // lane aligned data

   // one bit per entry, used for write, resolve and live masks
   typedef logic [`STBUF_DEPTH-1:0] entry_mask_t;

endpackage

/* src/stbuf_defs.svh */
//--------------------------------------------------------------------------
// store buffer sizing and timing constants
// pulled in by both packages and by any module that loops over
// entries or byte lanes
//--------------------------------------------------------------------------

`ifndef STBUF_DEFS_SVH
`define STBUF_DEFS_SVH

`define STBUF_DEPTH        4    // entries, power of two
`define STBUF_ADDR_W       16   // byte address bits
`define STBUF_DATA_W       32   // one word per entry
`define STBUF_BYTES        4    // lanes per entry

// cycles between the write edge and the commit/flush decision
`define STBUF_RESOLVE_LAT  2

`endif
